//--- compile.f
design/cpu8_pkg.sv
design/cpu8_alu.sv
design/cpu8_core.sv
design/cpu8_memory.sv
design/cpu8_system.sv
verif/cpu8_tb.sv

//--- design/cpu8_alu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu8_alu (
  input  logic [7:0]        a_operand,
  input  logic [7:0]        b_operand,
  input  cpu8_pkg::alu_op_e op,
  output logic [8:0]        result
);

  import cpu8_pkg::*;

  always_comb begin
    case (op)
      op_load_a: result = {1'b0, a_operand};
      op_load_b: result = {1'b0, b_operand};
      op_or: result = {1'b0, a_operand | b_operand};
      op_and: result = {1'b0, a_operand & b_operand};
      op_xor: result = {1'b0, a_operand ^ b_operand};
      // bit 8 carries out of inc and dec as well
      op_inc: result = {1'b0, a_operand} + 9'd1;
      op_dec: result = {1'b0, a_operand} - 9'd1;
      op_add: begin
        result = {1'b0, a_operand} + {1'b0, b_operand};
      end
      // borrow shows up as bit 8
      op_sub: begin
        result = {1'b0, a_operand} - {1'b0, b_operand};
      end
      op_asl: result = {a_operand, 1'b0};
      // old lsb goes out through bit 8
      op_lsr: begin
        result = {a_operand[0], 1'b0, a_operand[7:1]};
      end
      // nop and the unused codes give a defined zero
      default: result = 9'd0;
    endcase
  end

endmodule

`default_nettype wire

//--- design/cpu8_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu8_core (
  input  logic       clk,
  input  logic       reset,
  output logic [7:0] address,
  input  logic [7:0] data_in,
  output logic [7:0] data_out,
  output logic       write
);

  import cpu8_pkg::*;

  cpu_state_e state;

  // architectural registers
  logic [7:0] ip;
  logic [7:0] a;
  logic [7:0] b;
  logic       carry;
  logic       zero;

  // opcode latched at decode
  logic [7:0] opcode;

  // fields of the latched opcode
  alu_op_e    alu_op;
  dest_e      dest;
  logic       mem_operand;
  logic       flag_update;

  // fields of the byte being decoded
  logic [1:0] fetch_cls;
  logic [3:0] fetch_prefix;
  logic       carry_hit;
  logic       zero_hit;
  logic       branch_taken;

  logic [7:0] b_operand;
  logic [8:0] alu_result;

  assign alu_op      = alu_op_e'(opcode[field_op_msb:field_op_lsb]);
  assign dest        = dest_e'(opcode[field_dest_msb:field_dest_lsb]);
  assign mem_operand = opcode[field_mem_bit];
  assign flag_update = opcode[field_op_msb];

  assign fetch_cls    = data_in[field_cls_msb:field_cls_lsb];
  assign fetch_prefix = data_in[field_prefix_msb:field_prefix_lsb];

  // either enabled test may take the branch
  assign carry_hit    = data_in[br_carry_en] && (data_in[br_carry_val] == carry);
  assign zero_hit     = data_in[br_zero_en] && (data_in[br_zero_val] == zero);
  assign branch_taken = carry_hit || zero_hit;

  // immediate and memory forms both take the second operand from the bus
  assign b_operand = mem_operand ? data_in : b;

  cpu8_alu i_alu (
    .a_operand (a),
    .b_operand (b_operand),
    .op        (alu_op),
    .result    (alu_result)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_reset;
      write <= 1'b0;
      carry <= 1'b0;
      zero  <= 1'b0;
    end else begin
      case (state)
        st_reset: begin
          ip    <= reset_vector;
          carry <= 1'b0;
          zero  <= 1'b0;
          write <= 1'b0;
          state <= st_select;
        end

        // put the opcode address on the bus
        st_select: begin
          address <= ip;
          ip      <= ip + 8'd1;
          write   <= 1'b0;
          state   <= st_decode;
        end

        st_decode: begin
          opcode <= data_in;
          if (fetch_cls == cls_compute) begin
            state <= st_compute;
          end else if (fetch_cls == cls_compute_imm) begin
            // immediate byte follows the opcode
            address <= ip;
            ip      <= ip + 8'd1;
            state   <= st_compute;
          end else if (fetch_cls == cls_compute_mem) begin
            address <= b;
            state   <= st_compute;
          end else if (data_in == instr_store) begin
            address  <= b;
            data_out <= a;
            write    <= 1'b1;
            state    <= st_select;
          end else if (fetch_prefix == branch_prefix) begin
            // target byte is skipped when not taken
            ip <= ip + 8'd1;
            if (branch_taken) begin
              address <= ip;
              state   <= st_read_ip;
            end else begin
              state <= st_select;
            end
          end else if (fetch_prefix == const_a_prefix) begin
            a     <= {4'b0000, data_in[field_op_msb:field_op_lsb]};
            state <= st_select;
          end else if (fetch_prefix == const_b_prefix) begin
            b     <= {4'b0000, data_in[field_op_msb:field_op_lsb]};
            state <= st_select;
          end else begin
            // restart instruction and every illegal opcode
            state <= st_reset;
          end
        end

        st_compute: begin
          case (dest)
            dest_a: a <= alu_result[7:0];
            dest_b: b <= alu_result[7:0];
            dest_ip: ip <= alu_result[7:0];
            default: begin
            end
          endcase
          if (flag_update) begin
            carry <= alu_result[8];
          end
          // zero looks at all nine bits
          zero  <= ~|alu_result;
          state <= st_select;
        end

        // branch target arrives on the bus
        st_read_ip: begin
          ip    <= data_in;
          state <= st_select;
        end

        default: begin
          state <= st_reset;
        end
      endcase
    end
  end

  // state encoding stays valid once out of reset
  state_known_a: assert property (
    @(posedge clk) disable iff (reset) !$isunknown(state)
  );

  // a store strobe lasts a single cycle
  write_single_a: assert property (
    @(posedge clk) disable iff (reset) write |=> !write
  );

endmodule

`default_nettype wire

//--- design/cpu8_memory.sv
`timescale 1ns/1ps
`default_nettype none

module cpu8_memory (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] address,
  input  logic       write,
  input  logic [7:0] data_out,
  output logic [7:0] data_in,
  input  logic       load_en,
  input  logic [6:0] load_addr,
  input  logic [7:0] load_data
);

  import cpu8_pkg::*;

  // data ram at 0x00, program rom at 0x80
  logic [7:0] ram [ram_words];
  logic [7:0] rom [rom_words];

  logic       rom_sel;
  logic [6:0] offset;

  assign rom_sel = address[7];
  assign offset  = address[6:0];

  // asynchronous read, same cycle as the address
  always_comb begin
    if (rom_sel) begin
      data_in = rom[offset];
    end else begin
      data_in = ram[offset];
    end
  end

  // stores always land in ram, bit 7 is ignored
  always_ff @(posedge clk) begin
    if (write) begin
      ram[offset] <= data_out;
    end
  end

  // program load port
  always_ff @(posedge clk) begin
    if (load_en) begin
      rom[load_addr] <= load_data;
    end
  end

  // program may only be loaded while the system is held in reset
  load_in_reset_a: assert property (
    @(posedge clk) !reset |-> !load_en
  );

  // a core store and a rom load never share a cycle
  load_store_excl_a: assert property (
    @(posedge clk) !(load_en && write)
  );

endmodule

`default_nettype wire

//--- design/cpu8_pkg.sv
`default_nettype none

package cpu8_pkg;

  // core sequencing states
  typedef enum logic [2:0] {
    st_reset   = 3'd0,
    st_select  = 3'd1,
    st_decode  = 3'd2,
    st_compute = 3'd3,
    st_read_ip = 3'd4
  } cpu_state_e;

  // alu operation, instruction bits 3:0
  // codes 8 and above update carry
  typedef enum logic [3:0] {
    op_load_a = 4'd0,
    op_load_b = 4'd1,
    op_or     = 4'd2,
    op_and    = 4'd3,
    op_xor    = 4'd4,
    op_inc    = 4'd5,
    op_dec    = 4'd6,
    op_nop    = 4'd7,
    op_add    = 4'd8,
    op_sub    = 4'd9,
    op_asl    = 4'd10,
    op_lsr    = 4'd11
  } alu_op_e;

  // result destination, instruction bits 5:4
  typedef enum logic [1:0] {
    dest_a    = 2'd0,
    dest_b    = 2'd1,
    dest_ip   = 2'd2,
    dest_none = 2'd3
  } dest_e;

  // first fetch address, start of rom
  localparam logic [7:0] reset_vector = 8'h80;

  localparam int ram_words = 128;
  localparam int rom_words = 128;

  // instruction field positions
  localparam int field_op_lsb     = 0;
  localparam int field_op_msb     = 3;
  localparam int field_dest_lsb   = 4;
  localparam int field_dest_msb   = 5;
  localparam int field_mem_bit    = 6;
  localparam int field_cls_lsb    = 6;
  localparam int field_cls_msb    = 7;
  localparam int field_prefix_lsb = 4;
  localparam int field_prefix_msb = 7;

  // branch condition bits
  localparam int br_carry_en  = 0;
  localparam int br_carry_val = 1;
  localparam int br_zero_en   = 2;
  localparam int br_zero_val  = 3;

  // instruction classes and fixed encodings
  localparam logic [1:0] cls_compute     = 2'b00;
  localparam logic [1:0] cls_compute_imm = 2'b01;
  localparam logic [1:0] cls_compute_mem = 2'b11;
  localparam logic [7:0] instr_store     = 8'h80;
  localparam logic [7:0] instr_restart   = 8'h81;
  localparam logic [3:0] branch_prefix   = 4'b1001;
  localparam logic [3:0] const_a_prefix  = 4'b1010;
  localparam logic [3:0] const_b_prefix  = 4'b1011;

endpackage

`default_nettype wire

//--- design/cpu8_system.sv
`timescale 1ns/1ps
`default_nettype none

module cpu8_system (
  input  logic       clk,
  input  logic       reset,
  input  logic       load_en,
  input  logic [6:0] load_addr,
  input  logic [7:0] load_data,
  output logic [7:0] bus_address,
  output logic       bus_write,
  output logic [7:0] bus_data_out
);

  // core bus
  logic [7:0] core_address;
  logic [7:0] core_data_out;
  logic       core_write;
  logic [7:0] mem_data_in;

  cpu8_core i_core (
    .clk      (clk),
    .reset    (reset),
    .address  (core_address),
    .data_in  (mem_data_in),
    .data_out (core_data_out),
    .write    (core_write)
  );

  cpu8_memory i_memory (
    .clk       (clk),
    .reset     (reset),
    .address   (core_address),
    .write     (core_write),
    .data_out  (core_data_out),
    .data_in   (mem_data_in),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data)
  );

  // observation copies of the bus
  assign bus_address  = core_address;
  assign bus_write    = core_write;
  assign bus_data_out = core_data_out;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the cpu8 testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module cpu8_tb --Mdir obj_dir -o cpu8_sim -f compile.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/cpu8_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi

# result comes from the log
if grep -qx "sim passed" "$log"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

//--- verif/cpu8_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu8_tb;

  import cpu8_pkg::*;

  // cycles allowed for one program to reach its end
  localparam int run_limit = 400;
  localparam int num_programs = 8;
  localparam int prog_budget = 2 + rom_words + 2 + run_limit + 30;
  localparam int watchdog_cycles = num_programs * prog_budget;

  logic       clk;
  logic       reset;
  logic       load_en;
  logic [6:0] load_addr;
  logic [7:0] load_data;
  logic [7:0] bus_address;
  logic       bus_write;
  logic [7:0] bus_data_out;

  // program image and expected {address, data} of every store
  logic [7:0]  prog [$];
  logic [15:0] exp_log [$];
  logic [15:0] store_log [$];
  logic [7:0]  halt_addr;

  // reference state of the processor
  logic [7:0] m_a;
  logic [7:0] m_b;
  logic       m_c;
  logic       m_z;
  logic [7:0] m_ram [ram_words];

  int          fetch_count;
  logic [7:0]  last_addr;
  logic [31:0] rng_state;

  cpu8_system i_dut (
    .clk          (clk),
    .reset        (reset),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .bus_address  (bus_address),
    .bus_write    (bus_write),
    .bus_data_out (bus_data_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // stores and reset vector fetches sampled mid-cycle
  always @(negedge clk) begin
    if (reset) begin
      store_log.delete();
      fetch_count = 0;
      last_addr = 8'h00;
    end else begin
      if (bus_write) begin
        store_log.push_back({bus_address, bus_data_out});
      end
      if (bus_address === reset_vector && last_addr !== reset_vector) begin
        fetch_count++;
      end
      last_addr = bus_address;
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    fail_text("watchdog expired before the tests completed");
  end

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic fail_value(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    $display("mismatch at %0t: %s expected 8'h%02h, actual 8'h%02h",
             $time, name, expected, actual);
    abort_run();
  endtask

  task automatic fail_text(input string what);
    $display("error at %0t: %s", $time, what);
    abort_run();
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic alu_op_e random_op(input logic [31:0] r);
    case (r % 32'd7)
      32'd0: return op_add;
      32'd1: return op_sub;
      32'd2: return op_asl;
      32'd3: return op_lsr;
      32'd4: return op_and;
      32'd5: return op_or;
      default: return op_xor;
    endcase
  endfunction

  // nine-bit result with the carry or borrow out in bit 8
  function automatic logic [8:0] alu_model(input alu_op_e op, input logic [7:0] x,
                                           input logic [7:0] y);
    int xi;
    int yi;
    int s;
    xi = int'(x);
    yi = int'(y);
    case (op)
      op_load_a: s = xi;
      op_load_b: s = yi;
      op_or: s = xi | yi;
      op_and: s = xi & yi;
      op_xor: s = xi ^ yi;
      op_inc: s = xi + 1;
      op_dec: s = xi - 1;
      op_add: s = xi + yi;
      op_sub: s = xi - yi;
      op_asl: s = xi * 2;
      op_lsr: s = (xi >> 1) + (xi % 2) * 256;
      default: s = 0;
    endcase
    return s[8:0];
  endfunction

  function automatic logic [7:0] enc_alu(input logic [1:0] cls, input dest_e dest,
                                         input alu_op_e op);
    return {cls, dest, op};
  endfunction

  function automatic logic [7:0] enc_branch(input logic c_en, input logic c_val,
                                            input logic z_en, input logic z_val);
    return {branch_prefix, z_val, z_en, c_val, c_en};
  endfunction

  task automatic model_apply(input dest_e dest, input alu_op_e op, input logic [8:0] r);
    case (dest)
      dest_a: m_a = r[7:0];
      dest_b: m_b = r[7:0];
      default: begin
      end
    endcase
    if (op >= op_add) begin
      m_c = r[8];
    end
    m_z = (r == 9'd0);
  endtask

  task automatic start_program();
    prog.delete();
    exp_log.delete();
    m_a = 8'h00;
    m_b = 8'h00;
    m_c = 1'b0;
    m_z = 1'b0;
  endtask

  task automatic emit_imm(input dest_e dest, input alu_op_e op, input logic [7:0] imm);
    prog.push_back(enc_alu(cls_compute_imm, dest, op));
    prog.push_back(imm);
    model_apply(dest, op, alu_model(op, m_a, imm));
  endtask

  task automatic emit_reg(input dest_e dest, input alu_op_e op);
    prog.push_back(enc_alu(cls_compute, dest, op));
    model_apply(dest, op, alu_model(op, m_a, m_b));
  endtask

  task automatic emit_mem(input dest_e dest, input alu_op_e op);
    prog.push_back(enc_alu(cls_compute_mem, dest, op));
    model_apply(dest, op, alu_model(op, m_a, m_ram[m_b[6:0]]));
  endtask

  task automatic emit_const_a(input logic [3:0] k);
    prog.push_back({const_a_prefix, k});
    m_a = {4'h0, k};
  endtask

  task automatic emit_const_b(input logic [3:0] k);
    prog.push_back({const_b_prefix, k});
    m_b = {4'h0, k};
  endtask

  task automatic emit_store();
    prog.push_back(instr_store);
    exp_log.push_back({m_b, m_a});
    m_ram[m_b[6:0]] = m_a;
  endtask

  // branch on zero over a single store
  task automatic emit_skip_if_zero();
    prog.push_back(enc_branch(1'b0, 1'b0, 1'b1, 1'b1));
    prog.push_back(reset_vector + 8'(prog.size() + 2));
    if (m_z) begin
      prog.push_back(instr_store);
    end else begin
      emit_store();
    end
  endtask

  // jump to itself through the alu
  task automatic emit_halt();
    halt_addr = reset_vector + 8'(prog.size());
    prog.push_back(enc_alu(cls_compute_imm, dest_ip, op_load_b));
    prog.push_back(halt_addr);
  endtask

  task automatic check_stores(input string name, input bit exact);
    int i;
    logic [15:0] got;
    logic [15:0] want;
    assert (store_log.size() >= exp_log.size())
      else fail_text({name, ": fewer stores than expected"});
    if (exact) begin
      assert (store_log.size() == exp_log.size())
        else fail_text({name, ": more stores than expected"});
    end
    for (i = 0; i < exp_log.size(); i++) begin
      got = store_log[i];
      want = exp_log[i];
      assert (got[15:8] == want[15:8]) else fail_value("bus_address", want[15:8], got[15:8]);
      assert (got[7:0] == want[7:0]) else fail_value("bus_data_out", want[7:0], got[7:0]);
    end
  endtask

  // load under reset and wait for the end loop or enough stores after release
  task automatic run_program(input string name, input bit until_halt);
    int i;
    int cycles;
    next_cycle();
    reset = 1'b1;
    load_en = 1'b0;
    repeat (2) next_cycle();
    for (i = 0; i < prog.size(); i++) begin
      load_en = 1'b1;
      load_addr = i[6:0];
      load_data = prog[i];
      next_cycle();
    end
    load_en = 1'b0;
    reset = 1'b0;
    repeat (2) begin
      @(posedge clk);
      @(negedge clk);
      assert (bus_write == 1'b0) else fail_text({name, ": bus_write high after reset"});
    end
    assert (bus_address == reset_vector) else fail_value("bus_address", reset_vector, bus_address);
    cycles = 0;
    while ((until_halt && bus_address !== halt_addr) ||
           (!until_halt && store_log.size() < exp_log.size())) begin
      @(negedge clk);
      cycles++;
      assert (cycles <= run_limit) else fail_text({name, ": program did not finish in time"});
    end
    check_stores(name, until_halt);
  endtask

  task automatic test_reset();
    start_program();
    emit_halt();
    run_program("reset", 1'b1);
    repeat (20) @(negedge clk);
    assert (store_log.size() == 0) else fail_text("reset: store from a program without stores");
  endtask

  task automatic test_alu_ops();
    int i;
    alu_op_e op;
    start_program();
    for (i = 0; i < 12; i++) begin
      op = alu_op_e'(i[3:0]);
      // even codes use the immediate form, odd codes the register form
      if (i % 2 == 0) begin
        emit_imm(dest_a, op_load_b, 8'hc3 ^ i[7:0]);
        emit_imm(dest_a, op, 8'h5a + i[7:0]);
      end else begin
        emit_imm(dest_b, op_load_b, 8'h5a + i[7:0]);
        emit_imm(dest_a, op_load_b, 8'hc3 ^ i[7:0]);
        emit_reg(dest_a, op);
      end
      emit_imm(dest_b, op_load_b, 8'h10 + i[7:0]);
      emit_store();
    end
    emit_halt();
    run_program("alu operations", 1'b1);
  endtask

  task automatic test_random_ops();
    int i;
    start_program();
    for (i = 0; i < 12; i++) begin
      rng_state = xorshift32(rng_state);
      emit_imm(dest_a, op_load_b, rng_state[7:0]);
      emit_imm(dest_a, random_op(rng_state >> 16), rng_state[15:8]);
      emit_imm(dest_b, op_load_b, 8'h20 + i[7:0]);
      emit_store();
    end
    emit_halt();
    run_program("random operands", 1'b1);
  endtask

  task automatic test_carry_loop();
    logic [7:0] loop_addr;
    start_program();
    emit_const_a(4'd1);
    emit_const_b(4'd5);
    loop_addr = reset_vector + 8'(prog.size());
    prog.push_back(instr_store);
    prog.push_back(enc_alu(cls_compute, dest_a, op_asl));
    prog.push_back(enc_branch(1'b1, 1'b0, 1'b0, 1'b0));
    prog.push_back(loop_addr);
    emit_halt();
    // doubling sequence until the shift carries out
    while (!m_c) begin
      exp_log.push_back({m_b, m_a});
      model_apply(dest_a, op_asl, alu_model(op_asl, m_a, m_b));
    end
    run_program("carry loop", 1'b1);
  endtask

  task automatic test_zero_skip();
    start_program();
    emit_const_a(4'd1);
    emit_const_b(4'd6);
    emit_reg(dest_a, op_dec);
    emit_skip_if_zero();
    emit_store();
    emit_const_a(4'd2);
    emit_reg(dest_a, op_dec);
    emit_skip_if_zero();
    emit_halt();
    run_program("zero branch", 1'b1);
  endtask

  task automatic test_mem_read();
    start_program();
    emit_imm(dest_a, op_load_b, 8'h5a);
    emit_const_b(4'd4);
    emit_store();
    emit_imm(dest_a, op_load_b, 8'h33);
    emit_mem(dest_a, op_add);
    emit_const_b(4'd7);
    emit_store();
    emit_halt();
    run_program("memory read", 1'b1);
  endtask

  task automatic test_restart(input logic [7:0] restart_op, input string name);
    int i;
    start_program();
    emit_const_a(4'd7);
    emit_const_b(4'd2);
    emit_store();
    emit_reg(dest_a, op_inc);
    emit_store();
    prog.push_back(restart_op);
    // second pass repeats the same stores
    for (i = 0; i < 2; i++) begin
      exp_log.push_back(exp_log[i]);
    end
    run_program(name, 1'b0);
    assert (fetch_count >= 2) else fail_text({name, ": no second fetch from 0x80"});
  endtask

  initial begin
    reset = 1'b1;
    load_en = 1'b0;
    load_addr = 7'd0;
    load_data = 8'd0;
    rng_state = 32'h451d_8a27;
    test_reset();
    test_alu_ops();
    test_random_ops();
    test_carry_loop();
    test_zero_skip();
    test_mem_read();
    test_restart(instr_restart, "restart instruction");
    test_restart(8'h87, "illegal opcode");
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire
